/* tb/calc_stimulus.txt */
# Commands: click x y | alu value | expectEntry first op second
# probe x y videoOn expectedRgb, rgb in hex and all other fields decimal
expectEntry 103 103 103
probe 417 105 1 00
probe 545 121 1 00
probe 101 331 1 C0
# Operator before any digit is ignored
click 506 360
expectEntry 103 103 103
click 122 360
expectEntry 7 103 103
click 506 271
click 378 182
expectEntry 7 97 3
click 250 360
expectEntry 7 97 3
# Equals with a full expression, result 42
alu 42
click 506 182
probe 417 105 1 C0
probe 409 105 1 00
probe 441 73 1 C0
probe 433 73 1 00
probe 545 121 1 C0
probe 537 121 1 00
probe 553 73 1 C0
probe 545 73 1 00
# Clear, then equals with no second digit
click 592 182
expectEntry 103 103 103
probe 545 121 1 00
probe 417 105 1 00
click 506 182
probe 545 81 1 C0
probe 561 81 1 00
probe 577 97 1 C0
probe 417 105 1 00
# Clear again, then a fresh first digit
click 592 182
probe 545 81 1 00
click 250 271
expectEntry 5 103 103
# Blanking, cursor square and key gaps
probe 101 331 0 00
probe 254 267 1 FF
probe 246 275 1 FF
probe 255 271 1 00
probe 250 271 0 00
probe 170 182 1 00
probe 122 220 1 00

/* compile.f */
+incdir+src
src/videoPkg.sv
src/calcPkg.sv
src/glyphRom.sv
src/layoutDecoder.sv
src/entrySequencer.sv
src/pixelRenderer.sv
src/calcDisplayTop.sv
tb/calcDisplayTb.sv

/* Makefile */
SIM      := verilator
TOP      := calcDisplayTb
FILELIST := compile.f
FLAGS    := --binary --timing -j 0 --top-module $(TOP)

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)

/* tb/calcDisplayTb.sv */
`timescale 1ns/1ps
`default_nettype none

module calcDisplayTb import videoPkg::*, calcPkg::*; ();

   localparam real clockPeriod = 4.0;          // ns
   localparam real driveDelay  = 0.5;          // Input change after the rising edge
   localparam real pollStep    = 0.1;          // Edge counter sampling interval
   localparam int  maxLines    = 200;          // Upper bound on stimulus lines

   logic       pixel_tick = 1'b0;
   logic       rstN;
   screenPos_t mousePos;
   logic       mouseClick;
   screenPos_t pixelPos;
   logic       videoOn;
   result_t    aluResult;
   rgb_t       rgb;
   entry_t     entry;

   int      errorCount = 0;
   int      checkCount = 0;
   int      edgeCount  = 0;
   realtime lastEdge   = 0.0;
   logic    timedOut   = 1'b0;

   always #(clockPeriod / 2.0) pixel_tick = ~pixel_tick;

   // Rising edges so far and the time of the latest one
   always @(posedge pixel_tick) begin
      edgeCount++;
      lastEdge = $realtime;
   end

   calcDisplayTop calcDisplayTop_inst (
      .pixel_tick (pixel_tick),
      .rstN       (rstN),
      .mousePos   (mousePos),
      .mouseClick (mouseClick),
      .pixelPos   (pixelPos),
      .videoOn    (videoOn),
      .aluResult  (aluResult),
      .rgb        (rgb),
      .entry      (entry)
   );

   // Returns driveDelay after the last of count rising edges
   task automatic waitEdges(input int count);
      int      target;
      realtime deadline;
      target   = edgeCount + count;
      deadline = $realtime + (count + 2) * clockPeriod;
      while (edgeCount < target && $realtime < deadline) begin
         #pollStep;
      end
      if (edgeCount < target) begin
         errorCount++;
         timedOut = 1'b1;
         $display("Timeout: the clock stopped before %0d rising edges arrived", count);
      end else begin
         #(lastEdge + driveDelay - $realtime);
      end
   endtask

   task automatic compareValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("Error %s expected %h got %h", name, expected, actual);
      end
   endtask

   // One-cycle click strobe at a screen position
   task automatic clickAt(input int x, input int y);
      mousePos.x = coord_t'(x);
      mousePos.y = coord_t'(y);
      mouseClick = 1'b1;
      waitEdges(1);                            // Sequencer samples here
      mouseClick = 1'b0;
   endtask

   task automatic checkEntry(input int first, input int op, input int second);
      compareValue("entry.firstOperand", 32'(first), 32'(entry.firstOperand));
      compareValue("entry.operatorCode", 32'(op), 32'(entry.operatorCode));
      compareValue("entry.secondOperand", 32'(second), 32'(entry.secondOperand));
   endtask

   task automatic probePixel(input int x, input int y, input int video, input int expected);
      pixelPos.x = coord_t'(x);
      pixelPos.y = coord_t'(y);
      videoOn    = (video != 0);
      waitEdges(2);                            // Two pipeline stages
      if (!timedOut) begin
         compareValue($sformatf("rgb at %0d,%0d", x, y), 32'(expected), 32'(rgb));
      end
   endtask

   // Decode one stimulus line
   task automatic runCommand(input string line);
      string cmd;
      int    a;
      int    b;
      int    c;
      int    d;
      int    fields;
      fields = $sscanf(line, "%s", cmd);
      if (fields == 1 && cmd.getc(0) != "#") begin     // Skip blank and comment lines
         if (cmd == "click" && $sscanf(line, "%s %d %d", cmd, a, b) == 3) begin
            clickAt(a, b);
         end else if (cmd == "alu" && $sscanf(line, "%s %d", cmd, a) == 2) begin
            aluResult = result_t'(a);
         end else if (cmd == "expectEntry"
                      && $sscanf(line, "%s %d %d %d", cmd, a, b, c) == 4) begin
            checkEntry(a, b, c);
         end else if (cmd == "probe"
                      && $sscanf(line, "%s %d %d %d %h", cmd, a, b, c, d) == 5) begin
            probePixel(a, b, c, d);
         end else begin
            errorCount++;
            $display("Stimulus line not understood: %s", line);
         end
      end
   endtask

   initial begin
      string line;
      int    fd;
      int    lineNo;
      rstN       = 1'b0;
      mousePos   = '0;                         // Cursor parked in the corner
      mouseClick = 1'b0;
      pixelPos   = '0;
      videoOn    = 1'b0;
      aluResult  = '0;
      waitEdges(4);                            // Reset held 4 cycles
      rstN = 1'b1;

      fd = $fopen("tb/calc_stimulus.txt", "r");
      if (fd == 0) begin
         errorCount++;
         $display("Cannot open the stimulus file tb/calc_stimulus.txt");
      end else begin
         lineNo = 0;
         while (!$feof(fd) && lineNo < maxLines && !timedOut) begin
            if ($fgets(line, fd) > 0) begin
               runCommand(line);
            end
            lineNo++;
         end
         if (!$feof(fd) && !timedOut) begin
            errorCount++;
            $display("Stimulus file has more lines than the reader accepts");
         end
         $fclose(fd);
      end

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/calcDisplayTop.sv */
`timescale 1ns/1ps
`default_nettype none

module calcDisplayTop import videoPkg::*, calcPkg::*; (
   input  logic       pixel_tick,
   input  logic       rstN,
   input  screenPos_t mousePos,
   input  logic       mouseClick,    // One-cycle strobe
   input  screenPos_t pixelPos,      // From the VGA sync generator
   input  logic       videoOn,
   input  result_t    aluResult,
   output rgb_t       rgb,
   output entry_t     entry          // Operands and operator to the ALU
);

   layoutHit_t     pixelHit;
   layoutHit_t     mouseHit;
   displayDigits_t digits;
   glyphCode_t     glyphCode;
   glyphIndex_t    glyphRow;
   logic [7:0]     glyphBits;

   // Same layout map for the beam and the mouse
   layoutDecoder pixelDecoder_inst (
      .pos (pixelPos),
      .hit (pixelHit)
   );

   layoutDecoder mouseDecoder_inst (
      .pos (mousePos),
      .hit (mouseHit)
   );

   entrySequencer entrySequencer_inst (
      .pixel_tick (pixel_tick),
      .rstN       (rstN),
      .mouseHit   (mouseHit),
      .mouseClick (mouseClick),
      .aluResult  (aluResult),
      .entry      (entry),
      .digits     (digits)
   );

   pixelRenderer pixelRenderer_inst (
      .pixel_tick (pixel_tick),
      .rstN       (rstN),
      .pixelHit   (pixelHit),
      .pixelPos   (pixelPos),
      .mousePos   (mousePos),
      .videoOn    (videoOn),
      .digits     (digits),
      .glyphCode  (glyphCode),
      .glyphRow   (glyphRow),
      .glyphBits  (glyphBits),
      .rgb        (rgb)
   );

   glyphRom glyphRom_inst (
      .glyphCode (glyphCode),
      .glyphRow  (glyphRow),
      .glyphBits (glyphBits)
   );

endmodule

`default_nettype wire

/* src/pixelRenderer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calc_config.svh"

module pixelRenderer import videoPkg::*, calcPkg::*; (
   input  logic           pixel_tick,
   input  logic           rstN,
   input  layoutHit_t     pixelHit,      // Decoded current pixel
   input  screenPos_t     pixelPos,
   input  screenPos_t     mousePos,
   input  logic           videoOn,
   input  displayDigits_t digits,
   output glyphCode_t     glyphCode,     // Stage 1 ROM address
   output glyphIndex_t    glyphRow,
   input  logic [7:0]     glyphBits,     // ROM line for stage 1 address
   output rgb_t           rgb
);

   glyphCode_t  cellCode;
   logic        cursorHit;
   glyphIndex_t s1Col;
   logic        s1InRegion;
   logic        s1Cursor;
   logic        s1VideoOn;
   logic        glyphPixel;

   // Within CURSOR_HALF on one axis
   function automatic logic nearMouse(input coord_t pixel, input coord_t mouse);
      return int'(pixel) + `CURSOR_HALF >= int'(mouse)
             && int'(pixel) <= int'(mouse) + `CURSOR_HALF;
   endfunction

   always_comb begin
      case (pixelHit.region)
         regionKey:   cellCode = keypadMap[pixelHit.keyIndex];
         regionClear: cellCode = 7'(`GLYPH_CLEAR);
         regionTens:  cellCode = digits.tens;
         regionUnits: cellCode = digits.units;
         default:     cellCode = 7'(`GLYPH_BLANK);   // Background
      endcase
   end

   assign cursorHit = nearMouse(pixelPos.x, mousePos.x) && nearMouse(pixelPos.y, mousePos.y);

   // Stage 1 flags
   always_ff @(posedge pixel_tick or negedge rstN) begin
      if (!rstN) begin
         s1VideoOn  <= 1'b0;
         s1Cursor   <= 1'b0;
         s1InRegion <= 1'b0;
      end else begin
         s1VideoOn  <= videoOn;
         s1Cursor   <= cursorHit;
         s1InRegion <= pixelHit.region != regionNone;
      end
   end

   // Stage 1 glyph address
   always_ff @(posedge pixel_tick) begin
      glyphCode <= cellCode;
      glyphRow  <= pixelHit.glyphRow;
      s1Col     <= pixelHit.glyphCol;
   end

   assign glyphPixel = glyphBits[3'd7 - s1Col];   // MSB is left

   // Stage 2 colour, cursor on top of glyphs
   always_ff @(posedge pixel_tick or negedge rstN) begin
      if (!rstN) begin
         rgb <= `COLOR_BLACK;
      end else if (!s1VideoOn) begin
         rgb <= `COLOR_BLACK;                       // Blanking interval
      end else if (s1Cursor) begin
         rgb <= `COLOR_WHITE;
      end else if (s1InRegion && glyphPixel) begin
         rgb <= `COLOR_BLUE;
      end else begin
         rgb <= `COLOR_BLACK;
      end
   end

endmodule

`default_nettype wire

/* src/entrySequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calc_config.svh"

module entrySequencer import videoPkg::*, calcPkg::*; (
   input  logic           pixel_tick,
   input  logic           rstN,
   input  layoutHit_t     mouseHit,      // Decoded mouse position
   input  logic           mouseClick,    // One-cycle strobe
   input  result_t        aluResult,
   output entry_t         entry,         // To the ALU
   output displayDigits_t digits         // Result field contents
);

   entryState_t state;
   glyphCode_t  keyCode;
   logic        keyIsDigit;
   logic        keyIsOperator;
   logic        keyIsEquals;

   assign keyCode       = keypadMap[mouseHit.keyIndex];
   assign keyIsDigit    = keyCode <= 7'd9;
   assign keyIsOperator = keyCode >= 7'(`GLYPH_OP_FIRST) && keyCode <= 7'(`GLYPH_OP_LAST);
   assign keyIsEquals   = keyCode == 7'(`GLYPH_EQUALS);

   always_ff @(posedge pixel_tick or negedge rstN) begin
      if (!rstN) begin
         state  <= entryFirst;
         entry  <= blankEntry;
         digits <= blankDigits;
      end else if (mouseClick && mouseHit.region == regionClear) begin
         state  <= entryFirst;           // Same as reset
         entry  <= blankEntry;
         digits <= blankDigits;
      end else if (mouseClick && mouseHit.region == regionKey) begin
         if (keyIsEquals) begin          // Any state, state kept
            if (entry.secondOperand != 7'(`GLYPH_BLANK)) begin
               digits.units <= glyphCode_t'(aluResult % 7'd10);
               digits.tens  <= glyphCode_t'((aluResult % 7'd100) / 7'd10);
            end else begin
               digits.units <= 7'(`GLYPH_ERROR); // Incomplete expression
            end
         end else begin
            case (state)
               entryFirst: begin
                  if (keyIsDigit) begin
                     entry.firstOperand <= keyCode;
                     digits.units       <= keyCode;  // Echo
                     state              <= entryOperator;
                  end
               end
               entryOperator: begin
                  if (keyIsOperator) begin
                     entry.operatorCode <= keyCode;
                     digits.units       <= keyCode;
                     state              <= entrySecond;
                  end
               end
               entrySecond: begin
                  if (keyIsDigit) begin
                     entry.secondOperand <= keyCode;
                     digits.units        <= keyCode;
                     state               <= entryDone;
                  end
               end
               default: ;                // Done, wait for equals or clear
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* src/layoutDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calc_config.svh"

module layoutDecoder import videoPkg::*; (
   input  screenPos_t pos,           // Pixel or mouse position
   output layoutHit_t hit
);

   logic       keyColHit;
   logic       keyRowHit;
   logic [1:0] keyCol;
   logic [1:0] keyRow;
   coord_t     keyLeft;
   coord_t     keyTop;
   coord_t     cellLeft;             // Origin of whatever cell was hit
   coord_t     cellTop;

   // Half-open span of one cell
   function automatic logic inSpan(input coord_t value, input int start);
      return int'(value) >= start && int'(value) < start + `CELL_SIZE;
   endfunction

   always_comb begin
      keyColHit = 1'b0;
      keyCol    = '0;
      keyLeft   = '0;
      for (int c = 0; c < 4; c++) begin
         if (inSpan(pos.x, `KEYPAD_LEFT + c * `KEY_PITCH_X)) begin
            keyColHit = 1'b1;
            keyCol    = 2'(c);
            keyLeft   = coord_t'(`KEYPAD_LEFT + c * `KEY_PITCH_X);
         end
      end
   end

   always_comb begin
      keyRowHit = 1'b0;
      keyRow    = '0;
      keyTop    = '0;
      for (int r = 0; r < 4; r++) begin
         if (inSpan(pos.y, `KEYPAD_TOP + r * `KEY_PITCH_Y)) begin
            keyRowHit = 1'b1;
            keyRow    = 2'(r);
            keyTop    = coord_t'(`KEYPAD_TOP + r * `KEY_PITCH_Y);
         end
      end
   end

   always_comb begin
      hit.region   = regionNone;
      hit.keyIndex = {keyRow, keyCol};     // Row-major
      cellLeft     = '0;
      cellTop      = '0;
      if (keyColHit && keyRowHit) begin
         hit.region = regionKey;
         cellLeft   = keyLeft;
         cellTop    = keyTop;
      end else if (inSpan(pos.x, `CLEAR_LEFT) && inSpan(pos.y, `CLEAR_TOP)) begin
         hit.region = regionClear;
         cellLeft   = coord_t'(`CLEAR_LEFT);
         cellTop    = coord_t'(`CLEAR_TOP);
      end else if (inSpan(pos.x, `DISPLAY_LEFT) && inSpan(pos.y, `DISPLAY_TOP)) begin
         hit.region = regionTens;
         cellLeft   = coord_t'(`DISPLAY_LEFT);
         cellTop    = coord_t'(`DISPLAY_TOP);
      end else if (inSpan(pos.x, `DISPLAY_LEFT + `DISPLAY_PITCH)
                   && inSpan(pos.y, `DISPLAY_TOP)) begin
         hit.region = regionUnits;
         cellLeft   = coord_t'(`DISPLAY_LEFT + `DISPLAY_PITCH);
         cellTop    = coord_t'(`DISPLAY_TOP);
      end
      // Offset inside the cell, scaled down to glyph bits
      hit.glyphRow = glyphIndex_t'((pos.y - cellTop) >> `CELL_SHIFT);
      hit.glyphCol = glyphIndex_t'((pos.x - cellLeft) >> `CELL_SHIFT);
   end

endmodule

`default_nettype wire

/* src/glyphRom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "calc_config.svh"

module glyphRom import videoPkg::*, calcPkg::*; (
   input  glyphCode_t  glyphCode,
   input  glyphIndex_t glyphRow,     // 0 is the top row
   output logic [7:0]  glyphBits     // Bit 7 is the leftmost pixel
);

   logic [63:0] bitmap;              // Top row in the high byte

   always_comb begin
      case (glyphCode)
         7'd0:                  bitmap = 64'h3C666E7666663C00;
         7'd1:                  bitmap = 64'h1838181818187E00;
         7'd2:                  bitmap = 64'h3C66060C30607E00;
         7'd3:                  bitmap = 64'h3C66061C06663C00;
         7'd4:                  bitmap = 64'h0C1C3C6C7E0C0C00;
         7'd5:                  bitmap = 64'h7E607C0606663C00;
         7'd6:                  bitmap = 64'h3C607C6666663C00;
         7'd7:                  bitmap = 64'h7E060C1830303000;
         7'd8:                  bitmap = 64'h3C66663C66663C00;
         7'd9:                  bitmap = 64'h3C66663E060C3800;
         7'(`GLYPH_CLEAR):      bitmap = 64'h3C66606060663C00;
         7'(`GLYPH_ERROR):      bitmap = 64'h7E60607C60607E00;
         7'(`GLYPH_EQUALS):     bitmap = 64'h00007E007E000000;
         7'(`GLYPH_OP_FIRST):   bitmap = 64'h0018187E18180000; // Plus
         7'(`GLYPH_OP_FIRST + 1): bitmap = 64'h0000007E00000000; // Minus
         7'(`GLYPH_OP_FIRST + 2): bitmap = 64'h00663CFF3C660000; // Times
         7'(`GLYPH_OP_FIRST + 3): bitmap = 64'h02060C1830604000; // Divide
         7'(`GLYPH_OP_LAST):    bitmap = 64'h62660C1830664600; // Percent
         default:               bitmap = 64'h0;                // Blank and unused codes
      endcase
   end

   // Pick one 8-pixel line
   assign glyphBits = bitmap[8 * (3'd7 - glyphRow) +: 8];

endmodule

`default_nettype wire

/* src/calcPkg.sv */
`default_nettype none
`include "calc_config.svh"

package calcPkg;

   typedef logic [6:0] glyphCode_t;  // Digit value, ASCII letter or symbol code
   typedef logic [6:0] result_t;     // From the external ALU

   typedef struct packed {
      glyphCode_t firstOperand;
      glyphCode_t operatorCode;
      glyphCode_t secondOperand;
   } entry_t;

   typedef enum logic [1:0] {
      entryFirst,                    // Waiting for first digit
      entryOperator,
      entrySecond,
      entryDone                      // Only equals and clear act here
   } entryState_t;

   typedef struct packed {
      glyphCode_t tens;
      glyphCode_t units;
   } displayDigits_t;

   // Key glyphs, index is row*4 + column
   localparam glyphCode_t keypadMap [16] = '{
      7'd1, 7'd2,                    7'd3,                    7'(`GLYPH_EQUALS),
      7'd4, 7'd5,                    7'd6,                    7'(`GLYPH_OP_FIRST),
      7'd7, 7'd8,                    7'd9,                    7'(`GLYPH_OP_FIRST + 1),
      7'd0, 7'(`GLYPH_OP_FIRST + 2), 7'(`GLYPH_OP_FIRST + 3), 7'(`GLYPH_OP_LAST)
   };

   localparam entry_t blankEntry = '{7'(`GLYPH_BLANK), 7'(`GLYPH_BLANK), 7'(`GLYPH_BLANK)};
   localparam displayDigits_t blankDigits = '{7'(`GLYPH_BLANK), 7'(`GLYPH_BLANK)};

endpackage

`default_nettype wire

/* src/videoPkg.sv */
`default_nettype none

package videoPkg;

   typedef logic [9:0] coord_t;      // Screen x or y
   typedef logic [7:0] rgb_t;        // 8-bit pixel colour
   typedef logic [3:0] keyIndex_t;   // Row*4 + column
   typedef logic [2:0] glyphIndex_t; // Row or column inside an 8x8 glyph

   typedef struct packed {
      coord_t x;
      coord_t y;
   } screenPos_t;

   typedef enum logic [2:0] {
      regionNone,
      regionKey,                     // One of the 16 keypad cells
      regionClear,
      regionTens,                    // Result field, left cell
      regionUnits                    // Result field, right cell
   } region_t;

   typedef struct packed {
      region_t     region;
      keyIndex_t   keyIndex;         // Valid only for regionKey
      glyphIndex_t glyphRow;
      glyphIndex_t glyphCol;
   } layoutHit_t;

endpackage

`default_nettype wire

/* src/calc_config.svh */
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// Glyph cell geometry
`define CELL_SIZE      64         // Side of one glyph cell in pixels
`define CELL_SHIFT     3          // 8 screen pixels per glyph bit

// Keypad placement
`define KEYPAD_LEFT    90         // Left edge of key column 0
`define KEYPAD_TOP     150        // Top edge of key row 0
`define KEY_PITCH_X    128        // Column to column
`define KEY_PITCH_Y    89         // Row to row

// Clear key and result field
`define CLEAR_LEFT     560
`define CLEAR_TOP      150
`define DISPLAY_LEFT   406        // Tens cell left edge
`define DISPLAY_TOP    70
`define DISPLAY_PITCH  128        // Tens cell to units cell

`define CURSOR_HALF    4          // Cursor square is 2*4+1 wide

// Colours
`define COLOR_BLUE     8'hC0      // Glyph foreground
`define COLOR_BLACK    8'h00      // Background
`define COLOR_WHITE    8'hFF      // Cursor

// Glyph codes outside the digits
`define GLYPH_BLANK    103
`define GLYPH_ERROR    69         // ASCII E
`define GLYPH_CLEAR    67         // ASCII C
`define GLYPH_EQUALS   96
`define GLYPH_OP_FIRST 97         // Plus
`define GLYPH_OP_LAST  101        // Percent

`endif
